//--- nocRouterPkg.sv
package nocRouterPkg;

  // ################################################
  // Port set
  // ################################################
  localparam int numPorts = 5;

  typedef logic [2:0] portIdx_t;  // L=0 N=1 E=2 W=3 S=4

  // ################################################
  // Flit format
  // ################################################
  localparam int flitIdWidth = 3;
  localparam int dataWidth   = 16;
  localparam int lengthWidth = 12;  // Budget field in header data

  localparam logic [flitIdWidth-1:0] idHeader = 3'b001;
  localparam logic [flitIdWidth-1:0] idBody   = 3'b010;
  localparam logic [flitIdWidth-1:0] idTail   = 3'b100;

  typedef struct packed {
    logic [flitIdWidth-1:0] flitId;
    logic [dataWidth-1:0]   data;
  } flit_t;

  // ################################################
  // Input buffering
  // ################################################
  localparam int fifoDepth    = 8;
  localparam int fifoPtrWidth = $clog2(fifoDepth);
  localparam int fifoCntWidth = fifoPtrWidth + 1;

  // ################################################
  // Grant encoding
  // ################################################
  typedef logic [numPorts:0] grant_t;  // Bit 0 idle, bits 1..5 are L N E W S

  localparam grant_t grantIdle = grant_t'(1);

endpackage

//--- flitPortIf.sv
`timescale 1ns/10ps

interface flitPortIf
  import nocRouterPkg::*;
();

  flit_t head;        // Oldest buffered flit
  logic  notEmpty;
  logic  pop;         // Removes head at this edge
  logic  timesUp;     // Budget used up
  logic  grantStart;  // New grant begins next cycle

  modport fifoSide (
    output head,
    output notEmpty,
    input  pop
  );

  modport arbSide (
    input  notEmpty,
    input  timesUp,
    output pop,
    output grantStart
  );

  modport timerSide (
    input  head,
    input  pop,
    input  grantStart,
    output timesUp
  );

  modport muxSide (
    input head,
    input pop
  );

endinterface

//--- inputFifo.sv
`timescale 1ns/10ps

module inputFifo
  import nocRouterPkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        inValid,
  input  flit_t       inFlit,
  output logic        full,
  flitPortIf.fifoSide port
);

  flit_t                   mem [fifoDepth];
  logic [fifoPtrWidth-1:0] wrPtr;
  logic [fifoPtrWidth-1:0] rdPtr;
  logic [fifoCntWidth-1:0] count;
  logic                    doWrite;
  logic                    doRead;

  assign full          = (count == fifoCntWidth'(fifoDepth));
  assign port.notEmpty = (count != '0);
  assign port.head     = mem[rdPtr];  // Visible before the pop

  assign doWrite = inValid && !full;  // Write while full is lost
  assign doRead  = port.pop && port.notEmpty;

  // ################################################
  // Storage
  // ################################################
  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  // ################################################
  // Pointers and occupancy
  // ################################################
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
      begin
        wrPtr <= wrPtr + 1'b1;  // Depth is a power of two
      end
      if (doRead)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doWrite, doRead})
        2'b10:
        begin
          count <= count + 1'b1;
        end
        2'b01:
        begin
          count <= count - 1'b1;
        end
        default:
        begin
          count <= count;  // Idle or write with pop
        end
      endcase
    end
  end

endmodule

//--- grantTimer.sv
`timescale 1ns/10ps

module grantTimer
  import nocRouterPkg::*;
(
  input  logic         clk,
  input  logic         rst,
  flitPortIf.timerSide port
);

  logic [lengthWidth-1:0] limit;  // Flit budget, 0 means unlimited
  logic [lengthWidth-1:0] count;  // Flits popped in this grant
  logic                   headerPop;

  assign headerPop = port.pop && (port.head.flitId == idHeader);

  // ################################################
  // Budget and count registers
  // ################################################
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (headerPop)
      begin
        limit <= port.head.data[lengthWidth-1:0];
      end

      if (port.grantStart)
      begin
        count <= '0;
      end
      else if (headerPop)
      begin
        count <= lengthWidth'(1);  // Header is the first flit of the budget
      end
      else if (port.pop)
      begin
        count <= count + 1'b1;
      end
    end
  end

  assign port.timesUp = (limit != '0) && (count >= limit);

endmodule

//--- switchArbiter.sv
`timescale 1ns/10ps

module switchArbiter
  import nocRouterPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  flitPortIf.arbSide ports [numPorts]
);

  grant_t              grant;
  grant_t              nextGrant;
  portIdx_t            curIdx;
  logic                holding;
  logic [numPorts-1:0] req;
  logic [numPorts-1:0] tUp;
  logic [numPorts-1:0] popVec;
  logic [numPorts-1:0] startVec;

  // First requester after start in cyclic order, start itself last
  function automatic grant_t firstAfter(
    input logic [numPorts-1:0] reqs,
    input portIdx_t            start
  );
    grant_t sel;
    int     idx;
    logic   found;
    sel   = grantIdle;
    found = 1'b0;
    for (int k = 1; k <= numPorts; k++)
    begin
      idx = (int'(start) + k) % numPorts;
      if (!found && reqs[idx])
      begin
        sel        = '0;
        sel[idx+1] = 1'b1;
        found      = 1'b1;
      end
    end
    return sel;
  endfunction

  // ################################################
  // Port links
  // ################################################
  for (genvar i = 0; i < numPorts; i++)
  begin : gLink
    assign req[i]              = ports[i].notEmpty;
    assign tUp[i]              = ports[i].timesUp;
    assign ports[i].pop        = popVec[i];
    assign ports[i].grantStart = startVec[i];
  end

  // ################################################
  // Grant state
  // ################################################
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= grantIdle;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

  // ################################################
  // Next grant with rotating priority
  // ################################################
  always_comb
  begin
    curIdx = portIdx_t'(numPorts - 1);  // Idle searches from L
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i+1])
      begin
        curIdx = portIdx_t'(i);
      end
    end

    holding = !grant[0] && req[curIdx] && !tUp[curIdx];

    if (holding)
    begin
      nextGrant = grant;
    end
    else
    begin
      nextGrant = firstAfter(req, curIdx);
    end
  end

  // ################################################
  // Pop and timer start strobes
  // ################################################
  always_comb
  begin
    for (int i = 0; i < numPorts; i++)
    begin
      popVec[i] = grant[i+1] && req[i] && !tUp[i];
      // Self re-grant after time-up also restarts the count
      startVec[i] = nextGrant[i+1] && ((nextGrant != grant) || tUp[i]);
    end
  end

endmodule

//--- flitMux.sv
`timescale 1ns/10ps

module flitMux
  import nocRouterPkg::*;
(
  input  logic       clk,
  input  logic       rst,
  flitPortIf.muxSide ports [numPorts],
  output logic       outValid,
  output flit_t      outFlit,
  output portIdx_t   outPort
);

  flit_t               heads [numPorts];
  logic [numPorts-1:0] pops;
  flit_t               selFlit;
  portIdx_t            selIdx;
  logic                anyPop;

  for (genvar i = 0; i < numPorts; i++)
  begin : gTap
    assign heads[i] = ports[i].head;
    assign pops[i]  = ports[i].pop;
  end

  // At most one pop is active
  always_comb
  begin
    selFlit = heads[0];
    selIdx  = '0;
    anyPop  = 1'b0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (pops[i])
      begin
        selFlit = heads[i];
        selIdx  = portIdx_t'(i);
        anyPop  = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= anyPop;  // One cycle pulse per flit
    end
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
    outPort <= selIdx;
  end

endmodule

//--- nocOutputPort.sv
`timescale 1ns/10ps

module nocOutputPort
  import nocRouterPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [numPorts-1:0] inValid,
  input  flit_t               inFlit [numPorts],
  output logic [numPorts-1:0] full,
  output logic                outValid,
  output flit_t               outFlit,
  output portIdx_t            outPort
);

  flitPortIf portIf [numPorts] ();  // One link per input port

  // ################################################
  // Per-port buffer and grant timer
  // ################################################
  for (genvar i = 0; i < numPorts; i++)
  begin : gPort
    inputFifo uFifo (
      .clk     (clk),
      .rst     (rst),
      .inValid (inValid[i]),
      .inFlit  (inFlit[i]),
      .full    (full[i]),
      .port    (portIf[i])
    );

    grantTimer uTimer (
      .clk  (clk),
      .rst  (rst),
      .port (portIf[i])
    );
  end

  // ################################################
  // Shared output link
  // ################################################
  switchArbiter uArbiter (
    .clk   (clk),
    .rst   (rst),
    .ports (portIf)
  );

  flitMux uMux (
    .clk      (clk),
    .rst      (rst),
    .ports    (portIf),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

endmodule

//--- tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ##################################################
// Compare tasks
// ##################################################
task automatic compareFlit(input string what, input flit_t exp, input flit_t act);
  if (exp !== act)
    failRun($sformatf("[FAIL] %s: %s expected id=%b data=%h actual id=%b data=%h",
                      testName, what, exp.flitId, exp.data, act.flitId, act.data));
endtask

task automatic comparePort(input string what, input portIdx_t exp, input portIdx_t act);
  if (exp !== act)
    failRun($sformatf("[FAIL] %s: %s expected %0d actual %0d", testName, what, exp, act));
endtask

task automatic compareBit(input string what, input logic exp, input logic act);
  if (exp !== act)
    failRun($sformatf("[FAIL] %s: %s expected %b actual %b", testName, what, exp, act));
endtask

task automatic compareLevel(input string what, input logic [numPorts-1:0] exp,
                            input logic [numPorts-1:0] act);
  if (exp !== act)
    failRun($sformatf("[FAIL] %s: %s expected %b actual %b", testName, what, exp, act));
endtask

task automatic compareCount(input string what, input int exp, input int act);
  if (exp != act)
    failRun($sformatf("[FAIL] %s: %s expected %0d actual %0d", testName, what, exp, act));
endtask

// ##################################################
// Bounded waits
// ##################################################
task automatic waitOutValid(input int maxCycles);
  int n;
  n = 0;
  @(negedge clk);
  while (!outValid && n < maxCycles)
  begin
    @(negedge clk);
    n++;
  end
  if (!outValid)
    failRun($sformatf("%s: no flit appeared on the output in time", testName));
endtask

task automatic waitDrained(input int maxCycles);
  int n;
  n = 0;
  @(posedge clk);
  while (pendingFlits() != 0 && n < maxCycles)
  begin
    @(posedge clk);
    n++;
  end
  if (pendingFlits() != 0)
    failRun($sformatf("%s: written flits still missing on the output", testName));
  repeat (4) @(posedge clk);  // Grant falls back to idle
endtask

`endif

//--- tbNocOutputPort.sv
`timescale 1ns/10ps

module tbNocOutputPort
  import nocRouterPkg::*;
();

  logic                clk;
  logic                rst;
  logic [numPorts-1:0] inValid;
  flit_t               inFlit [numPorts];
  logic [numPorts-1:0] full;
  logic                outValid;
  flit_t               outFlit;
  portIdx_t            outPort;

  flit_t    expQ [numPorts][$];   // Scoreboard per input port
  flit_t    stage [numPorts][$];  // Not yet offered to the DUT
  portIdx_t seenPorts [$];        // Source order seen on the output
  flit_t    monFlit;
  string    testName;

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  `include "tbChecks.svh"

  nocOutputPort DUT (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inFlit   (inFlit),
    .full     (full),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // ##################################################
  // Output monitor
  // ##################################################
  always @(negedge clk)
  begin
    if (!rst && outValid)
    begin
      if (outPort >= numPorts)
        failRun("output port number is out of range");
      else if (expQ[outPort].size() == 0)
        failRun("a flit came out that was never written to that port");
      else
      begin
        monFlit = expQ[outPort].pop_front();
        compareFlit("output flit", monFlit, outFlit);
        seenPorts.push_back(outPort);
      end
    end
  end

  function automatic flit_t makeFlit(input logic [flitIdWidth-1:0] id,
                                     input logic [dataWidth-1:0] data);
    flit_t f;
    f.flitId = id;
    f.data   = data;
    return f;
  endfunction

  function automatic int pendingFlits();
    int n;
    n = 0;
    for (int p = 0; p < numPorts; p++)
      n += expQ[p].size();
    return n;
  endfunction

  task automatic stagePacket(input int p, input int nFlits, input int budget);
    logic [dataWidth-lengthWidth-1:0] upper;
    upper = (dataWidth - lengthWidth)'($urandom);
    stage[p].push_back(makeFlit(idHeader, {upper, lengthWidth'(budget)}));
    for (int k = 1; k < nFlits; k++)
      stage[p].push_back(makeFlit((k == nFlits - 1) ? idTail : idBody, dataWidth'($urandom)));
  endtask

  // One beat per cycle on every port with staged flits
  task automatic streamStaged();
    logic [numPorts-1:0] valid;
    flit_t               beat;
    valid = '1;
    while (valid != '0)
    begin
      @(negedge clk);
      for (int p = 0; p < numPorts; p++)
      begin
        valid[p] = (stage[p].size() != 0);
        beat     = '0;
        if (valid[p])
        begin
          if (full[p])
            failRun("a write was offered to a full FIFO");
          beat = stage[p].pop_front();
          expQ[p].push_back(beat);
        end
        inFlit[p] = beat;
      end
      inValid = valid;
    end
  endtask

  task automatic checkOrder(input portIdx_t order [$]);
    compareCount("flits delivered", order.size(), seenPorts.size());
    foreach (order[i])
      comparePort($sformatf("source of flit %0d", i), order[i], seenPorts[i]);
  endtask

  // ##################################################
  // Directed tests
  // ##################################################
  task automatic testResetState();
    testName = "reset state";
    repeat (2)
    begin
      @(negedge clk);
      compareBit("outValid in reset", 1'b0, outValid);
      compareLevel("full in reset", '0, full);
    end
    rst = 1'b0;
    repeat (3)
    begin
      @(negedge clk);
      compareBit("outValid after reset", 1'b0, outValid);
      compareLevel("full after reset", '0, full);
    end
  endtask

  task automatic testSinglePacket();
    portIdx_t order [$] = '{3'd2, 3'd2, 3'd2, 3'd2, 3'd2};
    testName = "single packet";
    seenPorts.delete();
    stagePacket(2, 5, 0);  // Header, three bodies, tail
    fork
      streamStaged();
      begin
        waitOutValid(20);
        repeat (4)
        begin
          @(negedge clk);
          compareBit("back to back outValid", 1'b1, outValid);
        end
      end
    join
    waitDrained(100);
    checkOrder(order);
  endtask

  task automatic testPriorityFromIdle();
    portIdx_t order [$] = '{3'd1, 3'd4};
    testName = "priority from idle";
    seenPorts.delete();
    stagePacket(4, 1, 0);
    stagePacket(1, 1, 0);
    streamStaged();
    waitDrained(100);
    checkOrder(order);
  endtask

  task automatic testBudgetPreemption();
    portIdx_t order [$] = '{3'd0, 3'd0, 3'd3, 3'd3, 3'd0, 3'd0, 3'd0, 3'd0};
    testName = "budget preemption";
    seenPorts.delete();
    stagePacket(0, 6, 2);
    stagePacket(3, 2, 0);
    streamStaged();
    waitDrained(100);
    checkOrder(order);
  endtask

  task automatic testAllPortsLoaded();
    int n;
    testName = "all ports loaded";
    seenPorts.delete();
    for (int p = 0; p < numPorts; p++)
      repeat (2)
      begin
        n = 1 + $urandom_range(3);  // At most fifoDepth flits per port
        stagePacket(p, n, $urandom_range(4));
      end
    streamStaged();
    waitDrained(400);
  endtask

  initial
  begin
    void'($urandom(32'h311a_6dbd));
    rst     = 1'b1;
    inValid = '0;
    for (int p = 0; p < numPorts; p++)
      inFlit[p] = '0;
    testResetState();
    testSinglePacket();
    testPriorityFromIdle();
    testBudgetPreemption();
    testAllPortsLoaded();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- src.f
+incdir+.
nocRouterPkg.sv
flitPortIf.sv
inputFifo.sv
grantTimer.sv
switchArbiter.sv
flitMux.sv
nocOutputPort.sv
tbNocOutputPort.sv

//--- Bender.yml
package:
  name: nocOutputPort

sources:
  - nocRouterPkg.sv
  - flitPortIf.sv
  - inputFifo.sv
  - grantTimer.sv
  - switchArbiter.sv
  - flitMux.sv
  - nocOutputPort.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbNocOutputPort.sv
